// File: common/core_pkg.sv
/*
  core datapath definitions
  register numbers, the flags word and where each flag sits in it.
  data words are DATA_W wide and set per instance
*/
package core_pkg;

  localparam int NUM_REGS = 16;

  // register number
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // carry, overflow, sign, zero from msb down
  typedef logic [3:0] flags_t;

  localparam int FLAG_C = 3;
  localparam int FLAG_V = 2;
  localparam int FLAG_S = 1;
  localparam int FLAG_Z = 0;

endpackage

// File: common/isa_pkg.sv
/*
  instruction set definitions
  the 40-bit instruction word layout, opcodes and condition codes
*/
package isa_pkg;

  typedef logic [39:0] insn_t;
  typedef logic [15:0] imm_t;
  typedef logic [3:0]  cond_t;

  // field lsb positions in insn_t
  localparam int OPC_LSB  = 32;
  localparam int COND_LSB = 28;
  localparam int RD_LSB   = 24;
  localparam int RA_LSB   = 20;
  localparam int RB_LSB   = 16;
  localparam int IMM_LSB  = 0;

  // any value not listed is executed as a no-op
  typedef enum logic [7:0] {
    op_add  = 8'h01,
    op_sub  = 8'h02,
    op_addi = 8'h03,
    op_and  = 8'h10,
    op_xor  = 8'h11,
    op_or   = 8'h12,
    op_shl  = 8'h20,
    op_shr  = 8'h21,
    op_sar  = 8'h22,
    op_sxt  = 8'h30,
    op_movi = 8'h31
  } opcode_e;

  localparam cond_t CC_EQ    = 4'd0;   // zero set
  localparam cond_t CC_NE    = 4'd1;
  localparam cond_t CC_CS    = 4'd2;   // carry set
  localparam cond_t CC_CC    = 4'd3;
  localparam cond_t CC_MI    = 4'd4;   // sign set
  localparam cond_t CC_PL    = 4'd5;
  localparam cond_t CC_VS    = 4'd6;   // overflow set
  localparam cond_t CC_VC    = 4'd7;
  localparam cond_t CC_HI    = 4'd8;   // unsigned above
  localparam cond_t CC_LS    = 4'd9;
  localparam cond_t CC_LT    = 4'd10;  // signed less
  localparam cond_t CC_GE    = 4'd11;
  localparam cond_t CC_GT    = 4'd12;
  localparam cond_t CC_LE    = 4'd13;
  localparam cond_t CC_AL    = 4'd14;
  localparam cond_t CC_NEVER = 4'd15;

endpackage

// File: verilog/decode_stage.sv
/*
  decode stage
  splits the instruction word, reads both sources with bypass of the
  result being written, selects the immediate operand and registers it all
*/
module decode_stage
  import core_pkg::*, isa_pkg::*;
#(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              insn_valid,
  input  insn_t             insn,
  input  logic [DATA_W-1:0] rf_ra_data,
  input  logic [DATA_W-1:0] rf_rb_data,
  input  logic              ex_write,
  input  reg_idx_t          ex_rd,
  input  logic [DATA_W-1:0] ex_data,
  output reg_idx_t          rf_ra_idx,
  output reg_idx_t          rf_rb_idx,
  output logic              dec_valid,
  output opcode_e           dec_op,
  output cond_t             dec_cond,
  output reg_idx_t          dec_rd,
  output logic [DATA_W-1:0] dec_a,
  output logic [DATA_W-1:0] dec_b
);

  opcode_e           op;
  cond_t             cond;
  reg_idx_t          rd;
  imm_t              imm;
  logic [DATA_W-1:0] imm_ext;
  logic [DATA_W-1:0] src_a;
  logic [DATA_W-1:0] src_b;
  logic              use_imm;

  assign op        = opcode_e'(insn[OPC_LSB +: $bits(opcode_e)]);
  assign cond      = insn[COND_LSB +: $bits(cond_t)];
  assign rd        = insn[RD_LSB +: $bits(reg_idx_t)];
  assign rf_ra_idx = insn[RA_LSB +: $bits(reg_idx_t)];
  assign rf_rb_idx = insn[RB_LSB +: $bits(reg_idx_t)];
  assign imm       = insn[IMM_LSB +: $bits(imm_t)];

  assign imm_ext = DATA_W'($signed(imm));
  assign use_imm = (op == op_addi) || (op == op_movi);

  // rf write lands on the same edge, so take it from execute
  assign src_a = (ex_write && ex_rd == rf_ra_idx) ? ex_data : rf_ra_data;
  assign src_b = (ex_write && ex_rd == rf_rb_idx) ? ex_data : rf_rb_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= insn_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (insn_valid) begin
      dec_op   <= op;
      dec_cond <= cond;
      dec_rd   <= rd;
      dec_a    <= src_a;
      dec_b    <= use_imm ? imm_ext : src_b;
    end
  end

endmodule

// File: verilog/execute_unit.sv
/*
  execute unit
  checks the condition code against the flags, runs the alu operation
  and forms the new flags. purely combinational
*/
module execute_unit
  import core_pkg::*, isa_pkg::*;
#(
  parameter int DATA_W = 64
) (
  input  logic              dec_valid,
  input  opcode_e           dec_op,
  input  cond_t             dec_cond,
  input  reg_idx_t          dec_rd,
  input  logic [DATA_W-1:0] dec_a,
  input  logic [DATA_W-1:0] dec_b,
  input  flags_t            flags,
  output logic              ex_write,
  output reg_idx_t          ex_rd,
  output logic [DATA_W-1:0] ex_data,
  output flags_t            ex_flags
);

  localparam int SH_W = $clog2(DATA_W);

  logic              c;
  logic              v;
  logic              s;
  logic              z;
  logic              cond_true;
  logic              legal;
  logic              arith;
  logic              is_sub;
  logic [DATA_W-1:0] b_op;
  logic [DATA_W:0]   sum;
  logic [SH_W-1:0]   sh;
  logic [DATA_W-1:0] sxt;
  logic [DATA_W-1:0] res;

  assign c = flags[FLAG_C];
  assign v = flags[FLAG_V];
  assign s = flags[FLAG_S];
  assign z = flags[FLAG_Z];

  always_comb begin
    cond_true = 1'b0;
    case (dec_cond)
      CC_EQ:    cond_true = z;
      CC_NE:    cond_true = !z;
      CC_CS:    cond_true = c;
      CC_CC:    cond_true = !c;
      CC_MI:    cond_true = s;
      CC_PL:    cond_true = !s;
      CC_VS:    cond_true = v;
      CC_VC:    cond_true = !v;
      CC_HI:    cond_true = c && !z;
      CC_LS:    cond_true = !c || z;
      CC_LT:    cond_true = s != v;
      CC_GE:    cond_true = s == v;
      CC_GT:    cond_true = !z && (s == v);
      CC_LE:    cond_true = z || (s != v);
      CC_AL:    cond_true = 1'b1;
      CC_NEVER: cond_true = 1'b0;
    endcase
  end

  // subtract is a + ~b + 1, carry out then means no borrow
  assign is_sub = (dec_op == op_sub);
  assign b_op   = is_sub ? ~dec_b : dec_b;
  assign sum    = {1'b0, dec_a} + {1'b0, b_op} + {{DATA_W{1'b0}}, is_sub};
  assign sh     = dec_b[SH_W-1:0];

  always_comb begin
    case (dec_b[1:0])
      2'd0:    sxt = DATA_W'($signed(dec_a[7:0]));
      2'd1:    sxt = DATA_W'($signed(dec_a[15:0]));
      2'd2:    sxt = DATA_W'($signed(dec_a[31:0]));
      default: sxt = dec_a;
    endcase
  end

  always_comb begin
    legal = 1'b1;
    arith = 1'b0;
    res   = '0;
    case (dec_op)
      op_add, op_sub, op_addi: begin
        res   = sum[DATA_W-1:0];
        arith = 1'b1;
      end
      op_and:  res = dec_a & dec_b;
      op_xor:  res = dec_a ^ dec_b;
      op_or:   res = dec_a | dec_b;
      op_shl:  res = dec_a << sh;
      op_shr:  res = dec_a >> sh;
      op_sar:  res = $unsigned($signed(dec_a) >>> sh);
      op_sxt:  res = sxt;
      op_movi: res = dec_b;  // already sign-extended in decode
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    ex_flags         = '0;
    ex_flags[FLAG_C] = arith && sum[DATA_W];
    ex_flags[FLAG_V] = arith && (dec_a[DATA_W-1] == b_op[DATA_W-1])
                       && (sum[DATA_W-1] != dec_a[DATA_W-1]);
    ex_flags[FLAG_S] = res[DATA_W-1];
    ex_flags[FLAG_Z] = ~|res;
  end

  assign ex_write = dec_valid && legal && cond_true;
  assign ex_rd    = dec_rd;
  assign ex_data  = res;

endmodule

// File: verilog/result_stage.sv
/*
  result stage
  register file with two async read ports, the flags register
  and the registered writeback outputs
*/
module result_stage
  import core_pkg::*;
#(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              ex_write,
  input  reg_idx_t          ex_rd,
  input  logic [DATA_W-1:0] ex_data,
  input  flags_t            ex_flags,
  input  reg_idx_t          rf_ra_idx,
  input  reg_idx_t          rf_rb_idx,
  output logic [DATA_W-1:0] rf_ra_data,
  output logic [DATA_W-1:0] rf_rb_data,
  output flags_t            flags,
  output logic              wb_valid,
  output reg_idx_t          wb_reg,
  output logic [DATA_W-1:0] wb_data
);

  logic [DATA_W-1:0] regs [NUM_REGS];

  assign rf_ra_data = regs[rf_ra_idx];
  assign rf_rb_data = regs[rf_rb_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ex_write) begin
      regs[ex_rd] <= ex_data;
    end
  end

  // flags only move on a committed write
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (ex_write) begin
      flags <= ex_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
      wb_reg   <= '0;
      wb_data  <= '0;
    end else begin
      wb_valid <= ex_write;
      wb_reg   <= ex_rd;
      wb_data  <= ex_data;
    end
  end

endmodule

// File: verilog/exec_core.sv
/*
  integer execution slice, top level
  decode, execute and result stages with one cycle to writeback
*/
module exec_core
  import core_pkg::*, isa_pkg::*;
#(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              insn_valid,
  input  insn_t             insn,
  output logic              wb_valid,
  output reg_idx_t          wb_reg,
  output logic [DATA_W-1:0] wb_data,
  output flags_t            flags
);

  reg_idx_t          rf_ra_idx;
  reg_idx_t          rf_rb_idx;
  logic [DATA_W-1:0] rf_ra_data;
  logic [DATA_W-1:0] rf_rb_data;

  logic              dec_valid;
  opcode_e           dec_op;
  cond_t             dec_cond;
  reg_idx_t          dec_rd;
  logic [DATA_W-1:0] dec_a;
  logic [DATA_W-1:0] dec_b;

  logic              ex_write;
  reg_idx_t          ex_rd;
  logic [DATA_W-1:0] ex_data;
  flags_t            ex_flags;

  decode_stage #(.DATA_W(DATA_W)) u_decode (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .rf_ra_data (rf_ra_data),
    .rf_rb_data (rf_rb_data),
    .ex_write   (ex_write),
    .ex_rd      (ex_rd),
    .ex_data    (ex_data),
    .rf_ra_idx  (rf_ra_idx),
    .rf_rb_idx  (rf_rb_idx),
    .dec_valid  (dec_valid),
    .dec_op     (dec_op),
    .dec_cond   (dec_cond),
    .dec_rd     (dec_rd),
    .dec_a      (dec_a),
    .dec_b      (dec_b)
  );

  execute_unit #(.DATA_W(DATA_W)) u_execute (
    .dec_valid (dec_valid),
    .dec_op    (dec_op),
    .dec_cond  (dec_cond),
    .dec_rd    (dec_rd),
    .dec_a     (dec_a),
    .dec_b     (dec_b),
    .flags     (flags),
    .ex_write  (ex_write),
    .ex_rd     (ex_rd),
    .ex_data   (ex_data),
    .ex_flags  (ex_flags)
  );

  result_stage #(.DATA_W(DATA_W)) u_result (
    .clk        (clk),
    .rst        (rst),
    .ex_write   (ex_write),
    .ex_rd      (ex_rd),
    .ex_data    (ex_data),
    .ex_flags   (ex_flags),
    .rf_ra_idx  (rf_ra_idx),
    .rf_rb_idx  (rf_rb_idx),
    .rf_ra_data (rf_ra_data),
    .rf_rb_data (rf_rb_data),
    .flags      (flags),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

endmodule

// File: dv/exec_asserts.sv
/*
  exec_core timing assertions
  reset state of writeback and the one-cycle path to wb
*/
module exec_asserts
  import core_pkg::*, isa_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     insn_valid,
  input insn_t    insn,
  input logic     wb_valid,
  input reg_idx_t wb_reg
);
  timeunit 1ns;
  timeprecision 1ps;

  wb_quiet_after_reset: assert property (@(posedge clk) $past(rst) |-> !wb_valid)
    else $error("wb_valid high in the cycle after reset");

  // insn sampled at edge n is on wb when sampled at edge n+2
  wb_needs_insn: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> $past(insn_valid, 2))
    else $error("wb_valid without an accepted instruction");

  wb_reg_is_rd: assert property (@(posedge clk) disable iff (rst)
    wb_valid |-> wb_reg == $past(insn[RD_LSB +: 4], 2))
    else $error("wb_reg differs from the rd of the accepted instruction");

endmodule

// File: dv/exec_checker.sv
/*
  exec_core checker
  in-order reference model of the slice, compares writeback and flags
  and keeps the per-test and total counts
*/
module exec_checker
  import core_pkg::*, isa_pkg::*;
#(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              insn_valid,
  input  insn_t             insn,
  input  logic              wb_valid,
  input  reg_idx_t          wb_reg,
  input  logic [DATA_W-1:0] wb_data,
  input  flags_t            flags,
  output logic              idle
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SH_W = $clog2(DATA_W);

  logic [DATA_W-1:0] mregs [NUM_REGS];
  flags_t            mflags;
  logic              pend_acc;   // accepted at the last edge
  logic              pend_wr;
  reg_idx_t          pend_reg;
  logic [DATA_W-1:0] pend_data;
  logic              exp_acc;    // on the wb outputs now
  logic              exp_wr;
  reg_idx_t          exp_reg;
  logic [DATA_W-1:0] exp_data;
  flags_t            exp_flags;
  int                checks = 0;
  int                errors = 0;
  int                tests = 0;
  int                test_checks = 0;
  int                test_errors = 0;

  function automatic logic cond_holds(input cond_t cc, input flags_t f);
    case (cc)
      4'd0:    return f[FLAG_Z];
      4'd1:    return !f[FLAG_Z];
      4'd2:    return f[FLAG_C];
      4'd3:    return !f[FLAG_C];
      4'd4:    return f[FLAG_S];
      4'd5:    return !f[FLAG_S];
      4'd6:    return f[FLAG_V];
      4'd7:    return !f[FLAG_V];
      4'd8:    return f[FLAG_C] && !f[FLAG_Z];
      4'd9:    return !f[FLAG_C] || f[FLAG_Z];
      4'd10:   return f[FLAG_S] != f[FLAG_V];
      4'd11:   return f[FLAG_S] == f[FLAG_V];
      4'd12:   return !f[FLAG_Z] && (f[FLAG_S] == f[FLAG_V]);
      4'd13:   return f[FLAG_Z] || (f[FLAG_S] != f[FLAG_V]);
      4'd14:   return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // false for an illegal opcode
  function automatic logic alu_model(input logic [7:0] op, input logic [DATA_W-1:0] a,
                                     input logic [DATA_W-1:0] b,
                                     output logic [DATA_W-1:0] r, output flags_t f);
    logic [DATA_W:0] wide;
    int              n;
    int              ext_w;
    f = '0;
    r = '0;
    n = int'(b[SH_W-1:0]);
    ext_w = (b[1:0] == 2'd0) ? 8 : (b[1:0] == 2'd1) ? 16 : (b[1:0] == 2'd2) ? 32 : DATA_W;
    case (op)
      op_add, op_addi: begin
        r = a + b;
        wide = {a[DATA_W-1], a} + {b[DATA_W-1], b};
        f[FLAG_C] = (r < a);  // unsigned wrap
        f[FLAG_V] = wide[DATA_W] != wide[DATA_W-1];
      end
      op_sub: begin
        r = a - b;
        wide = {a[DATA_W-1], a} - {b[DATA_W-1], b};
        f[FLAG_C] = (a >= b);
        f[FLAG_V] = wide[DATA_W] != wide[DATA_W-1];
      end
      op_and: r = a & b;
      op_xor: r = a ^ b;
      op_or:  r = a | b;
      op_shl: r = a << n;
      op_shr: r = a >> n;
      op_sar: begin
        for (int i = 0; i < DATA_W; i++) begin
          r[i] = (i + n < DATA_W) ? a[i + n] : a[DATA_W-1];
        end
      end
      op_sxt: begin
        for (int i = 0; i < DATA_W; i++) begin
          r[i] = (i < ext_w) ? a[i] : a[ext_w-1];
        end
      end
      op_movi: r = b;
      default: return 1'b0;
    endcase
    f[FLAG_S] = r[DATA_W-1];
    f[FLAG_Z] = (r == '0);
    return 1'b1;
  endfunction

  task automatic compare(input string name, input logic [63:0] act, input logic [63:0] exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at time %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-12s %0d checks, %0d errors", name, checks - test_checks,
             errors - test_errors);
    test_checks = checks;
    test_errors = errors;
    tests++;
  endtask

  task automatic print_summary();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
  endtask

  always @(posedge clk) begin : model
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] r;
    flags_t            f;
    logic              wr;
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        mregs[i] = '0;
      end
      mflags    = '0;
      pend_acc  = 1'b0;
      pend_wr   = 1'b0;
      exp_acc   = 1'b0;
      exp_wr    = 1'b0;
      exp_flags = '0;
    end else begin
      exp_acc   = pend_acc;
      exp_wr    = pend_wr;
      exp_reg   = pend_reg;
      exp_data  = pend_data;
      exp_flags = mflags;  // flags after the older instruction
      pend_acc  = insn_valid;
      pend_wr   = 1'b0;
      if (insn_valid) begin
        a = mregs[insn[RA_LSB +: 4]];
        b = mregs[insn[RB_LSB +: 4]];
        if (insn[OPC_LSB +: 8] == op_addi || insn[OPC_LSB +: 8] == op_movi) begin
          b = {{(DATA_W-16){insn[15]}}, insn[15:0]};
        end
        wr = alu_model(insn[OPC_LSB +: 8], a, b, r, f);
        wr = wr && cond_holds(insn[COND_LSB +: 4], mflags);
        if (wr) begin
          mregs[insn[RD_LSB +: 4]] = r;
          mflags = f;
        end
        pend_wr   = wr;
        pend_reg  = insn[RD_LSB +: 4];
        pend_data = r;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      compare("wb_valid", 64'(wb_valid), 64'(exp_wr));
      if (exp_wr) begin
        compare("wb_reg", 64'(wb_reg), 64'(exp_reg));
        compare("wb_data", 64'(wb_data), 64'(exp_data));
      end
      compare("flags", 64'(flags), 64'(exp_flags));
    end
  end

  // nothing in flight in the model and the DUT writeback quiet
  assign idle = !pend_acc && !exp_acc && !wb_valid;

endmodule

// File: dv/tb_top.sv
/*
  exec_core testbench
  seeded random instruction streams, checked by exec_checker
*/
module tb_top
  import core_pkg::*, isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_W       = 64;
  localparam int SEED         = 30109;
  localparam int HALF_PERIOD  = 5;
  localparam int DRIVE_DLY    = 1;
  localparam int NUM_RANDOM   = 300;
  localparam int IDLE_TIMEOUT = 20;
  localparam logic [7:0] ALL_OPS [11] = '{op_add, op_sub, op_addi, op_and, op_xor, op_or,
                                          op_shl, op_shr, op_sar, op_sxt, op_movi};

  logic              clk = 1'b0;
  logic              rst;
  logic              insn_valid;
  insn_t             insn;
  logic              wb_valid;
  reg_idx_t          wb_reg;
  logic [DATA_W-1:0] wb_data;
  flags_t            flags;
  logic              idle;
  logic              timed_out = 1'b0;

  always #HALF_PERIOD clk = ~clk;

  exec_core #(.DATA_W(DATA_W)) UUT (.*);

  exec_checker #(.DATA_W(DATA_W)) u_checker (.*);

  bind exec_core exec_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg)
  );

  function automatic insn_t make_insn(input logic [7:0] op, input cond_t cc,
                                      input reg_idx_t rd, input reg_idx_t ra,
                                      input reg_idx_t rb, input imm_t imm);
    return {op, cc, rd, ra, rb, imm};
  endfunction

  task automatic issue(input insn_t word);
    insn_valid = 1'b1;
    insn       = word;
    @(posedge clk);
    #DRIVE_DLY;
    insn_valid = 1'b0;
  endtask

  // op from ALL_OPS[lo..hi], random fields, sometimes a bubble after
  task automatic issue_random(input int lo, input int hi, input cond_t cc);
    issue(make_insn(ALL_OPS[4'($urandom_range(hi, lo))], cc, reg_idx_t'($urandom),
                    reg_idx_t'($urandom), reg_idx_t'($urandom), imm_t'($urandom)));
    if ($urandom_range(7, 0) == 0) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  // wide random values in r0..r14, r15 is scratch
  task automatic fill_regs();
    for (int r = 0; r < NUM_REGS - 1; r++) begin
      issue(make_insn(op_movi, CC_AL, reg_idx_t'(r), '0, '0, imm_t'($urandom)));
      repeat (DATA_W / 16 - 1) begin
        issue(make_insn(op_movi, CC_AL, 4'd15, '0, '0, 16'd16));
        issue(make_insn(op_shl, CC_AL, reg_idx_t'(r), reg_idx_t'(r), 4'd15, '0));
        issue(make_insn(op_movi, CC_AL, 4'd15, '0, '0, imm_t'($urandom)));
        issue(make_insn(op_xor, CC_AL, reg_idx_t'(r), reg_idx_t'(r), 4'd15, '0));
      end
    end
  endtask

  task automatic wait_idle(input string name);
    int cycles;
    cycles = 0;
    insn_valid = 1'b0;
    while (!idle && cycles < IDLE_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    if (!idle) begin
      $display("timeout: DUT did not go idle in test %s", name);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_test(input int t);
    string    name;
    reg_idx_t rd;
    reg_idx_t prev_rd;
    case (t)
      0: begin
        name = "reset";
        for (int r = 0; r < NUM_REGS; r++) begin
          issue(make_insn(op_add, CC_AL, reg_idx_t'(r), reg_idx_t'(r), reg_idx_t'(r), '0));
        end
      end
      1: begin
        name = "arith";
        fill_regs();
        repeat (NUM_RANDOM) issue_random(0, 2, CC_AL);
      end
      2: begin
        name = "logic";
        fill_regs();
        repeat (NUM_RANDOM) issue_random(3, 10, CC_AL);
      end
      3: begin
        name = "conditional";
        repeat (NUM_RANDOM) begin
          issue_random(0, 2, CC_AL);  // sets the flags
          if ($urandom_range(3, 0) == 0) begin
            issue(make_insn(8'h40 + 8'($urandom_range(63, 0)), cond_t'($urandom),
                            reg_idx_t'($urandom), reg_idx_t'($urandom),
                            reg_idx_t'($urandom), imm_t'($urandom)));
          end else begin
            issue_random(0, 10, cond_t'($urandom));
          end
        end
      end
      default: begin
        name = "dependency";
        prev_rd = '0;
        repeat (NUM_RANDOM) begin
          rd = reg_idx_t'($urandom);
          issue(make_insn(ALL_OPS[4'($urandom_range(10, 0))], CC_AL, rd, prev_rd,
                          ($urandom_range(1, 0) == 0) ? prev_rd : reg_idx_t'($urandom),
                          imm_t'($urandom)));
          prev_rd = rd;
        end
      end
    endcase
    wait_idle(name);
    if (!timed_out) begin
      u_checker.end_test(name);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst        = 1'b1;
    insn_valid = 1'b0;
    insn       = '0;
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    for (int t = 0; t < 5 && !timed_out; t++) begin
      run_test(t);
    end

    u_checker.print_summary();
    if (timed_out || u_checker.errors != 0) begin
      $display("Done: errors found");
    end else begin
      $display("Done: no errors");
    end
    $finish;
  end

endmodule

// File: tb.f
common/core_pkg.sv
common/isa_pkg.sv
verilog/decode_stage.sv
verilog/execute_unit.sv
verilog/result_stage.sv
verilog/exec_core.sv
dv/exec_asserts.sv
dv/exec_checker.sv
dv/tb_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      := -sv --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall
TOP        := tb_top
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Done: errors found
PASS_MSG   := Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(FLAGS) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --binary --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
